// File: design/video_dma_pkg.sv
// Shared geometry, FIFO marks, read limits and bus structures for the video DMA
package video_dma_pkg;

	// Frame geometry kept small for simulation
	localparam int PIXELS = 8;
	localparam int LINES = 4;
	localparam int FRAME_WORDS = PIXELS * LINES;

	// Pixel index width holds FRAME_WORDS minus one
	localparam int ADDR_W = $clog2(FRAME_WORDS);
	localparam logic [ADDR_W-1:0] FRAME_LAST = ADDR_W'(FRAME_WORDS - 1);

	// 24-bit pixel carried in the low bits of each memory word
	localparam int PIXEL_W = 24;

	// Pixel FIFO sizing
	localparam int FIFO_DEPTH = 32;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = FIFO_PTR_W + 1;
	// Nearly empty below this
	localparam int FIFO_LOW_MARK = 8;
	// Nearly full at or above this
	localparam int FIFO_HIGH_MARK = 24;

	// Outstanding read limits with hysteresis
	localparam int MAX_PENDING = 12;
	localparam int RESUME_PENDING = 7;
	// Room for MAX_PENDING plus the one accepted on the stall edge
	localparam int PENDING_W = $clog2(MAX_PENDING + 2);

	// Buffer bases after reset
	localparam logic [31:0] DEFAULT_FRONT_BASE = 32'h0000_1000;
	localparam logic [31:0] DEFAULT_BACK_BASE = 32'h0000_2000;

	// Slave register map
	localparam logic [1:0] REG_FRONT = 2'd0;
	localparam logic [1:0] REG_BACK = 2'd1;
	localparam logic [1:0] REG_GEOMETRY = 2'd2;
	localparam logic [1:0] REG_STATUS = 2'd3;

	// Slave command strobes and payload
	typedef struct packed {
		logic [1:0]  address;
		logic [3:0]  byteenable;
		logic        read;
		logic        write;
		logic [31:0] writedata;
	} slave_cmd_t;

	// Memory side of the read master
	typedef struct packed {
		logic [31:0] readdata;
		logic        readdatavalid;
		logic        waitrequest;
	} mem_rsp_t;

	// One FIFO entry with packet marks
	typedef struct packed {
		logic [PIXEL_W-1:0] data;
		logic               sop;
		logic               eop;
	} pixel_beat_t;

endpackage

// File: design/video_dma_regs.sv
// Slave register decoder holding the buffer bases, the swap request and readback
module video_dma_regs (
	input  logic                      clk,
	input  logic                      reset,
	input  video_dma_pkg::slave_cmd_t slave_cmd,
	input  logic                      frame_done,
	output logic [31:0]               slave_readdata,
	output logic [31:0]               front_base
);
	import video_dma_pkg::*;

	logic [31:0] back_base;
	logic        swap_pending;
	logic        write_front;
	logic        write_back;
	logic        do_swap;

	// Address decode of the write strobe
	assign write_front = slave_cmd.write && (slave_cmd.address == REG_FRONT);
	assign write_back = slave_cmd.write && (slave_cmd.address == REG_BACK);

	// Exchange only at the end of the frame being fetched
	assign do_swap = frame_done && swap_pending;

	// Base registers
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			front_base <= DEFAULT_FRONT_BASE;
			back_base <= DEFAULT_BACK_BASE;
		end
		else
		begin
			if (do_swap)
			begin
				front_base <= back_base;
				back_base <= front_base;
			end
			// Byte lanes written after the swap take precedence
			for (int b = 0; b < 4; b++)
			begin
				if (write_back && slave_cmd.byteenable[b])
					back_base[8*b +: 8] <= slave_cmd.writedata[8*b +: 8];
			end
		end
	end

	// Any write to the front address requests a swap
	always_ff @(posedge clk)
	begin
		if (reset)
			swap_pending <= 1'b0;
		else if (write_front)
			swap_pending <= 1'b1;
		else if (do_swap)
			swap_pending <= 1'b0;
	end

	// Registered readback, held until the next read
	always_ff @(posedge clk)
	begin
		if (reset)
			slave_readdata <= 32'h0000_0000;
		else if (slave_cmd.read)
		begin
			case (slave_cmd.address)
				REG_FRONT: slave_readdata <= front_base;
				REG_BACK: slave_readdata <= back_base;
				// Lines in the upper half, pixels in the lower
				REG_GEOMETRY: slave_readdata <= {16'(LINES), 16'(PIXELS)};
				// Index width, fixed id nibble, swap flag
				default: slave_readdata <= {16'(ADDR_W + 1), 8'h00, 4'h3, 2'b00, 1'b1,
					swap_pending};
			endcase
		end
	end

endmodule

// File: design/video_dma_fetch.sv
// Fetch engine issuing pixel reads and framing returned words into packets
module video_dma_fetch (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [31:0]                front_base,
	input  video_dma_pkg::mem_rsp_t    mem_rsp,
	input  logic                       fifo_low,
	input  logic                       fifo_high,
	output logic [31:0]                master_address,
	output logic                       master_read,
	output logic                       master_arbiterlock,
	output logic                       frame_done,
	output logic                       beat_write,
	output video_dma_pkg::pixel_beat_t beat
);
	import video_dma_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_STALL,
		ST_WAIT_LAST
	} state_t;

	state_t               state;
	state_t               state_next;
	logic [ADDR_W-1:0]    pixel_index;
	logic [ADDR_W-1:0]    rsp_index;
	logic [PENDING_W-1:0] pending_count;
	logic                 accept;
	logic                 last_pixel;

	// Read accepted when not held off by the slave
	assign accept = master_read && !mem_rsp.waitrequest;
	assign last_pixel = (pixel_index == FRAME_LAST);
	// One-cycle pulse on the accepted read of the last pixel
	assign frame_done = accept && last_pixel;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			// Start once the FIFO runs nearly empty
			ST_IDLE:
				if (fifo_low)
					state_next = ST_READ;
			// Decide only on an accepted read
			ST_READ:
				if (accept)
				begin
					if (last_pixel)
						state_next = ST_WAIT_LAST;
					else if (fifo_high)
						state_next = ST_IDLE;
					else if (pending_count >= PENDING_W'(MAX_PENDING))
						state_next = ST_STALL;
				end
			// Hysteresis on the outstanding count
			ST_STALL:
				if (pending_count <= PENDING_W'(RESUME_PENDING))
					state_next = ST_READ;
			// Drain the frame before going idle
			ST_WAIT_LAST:
				if (pending_count == '0)
					state_next = ST_IDLE;
			default:
				state_next = ST_IDLE;
		endcase
	end

	// Pixel index wraps after the last word of the frame
	always_ff @(posedge clk)
	begin
		if (reset)
			pixel_index <= '0;
		else if (accept)
			pixel_index <= last_pixel ? '0 : pixel_index + 1'b1;
	end

	// Outstanding reads, accept and response may coincide
	always_ff @(posedge clk)
	begin
		if (reset)
			pending_count <= '0;
		else
		begin
			case ({accept, mem_rsp.readdatavalid})
				2'b10: pending_count <= pending_count + 1'b1;
				2'b01: pending_count <= pending_count - 1'b1;
				default: pending_count <= pending_count;
			endcase
		end
	end

	// Position of the next returned word within its frame
	always_ff @(posedge clk)
	begin
		if (reset)
			rsp_index <= '0;
		else if (mem_rsp.readdatavalid)
			rsp_index <= (rsp_index == FRAME_LAST) ? '0 : rsp_index + 1'b1;
	end

	// word address from base and pixel index
	assign master_address = front_base + {{(30 - ADDR_W){1'b0}}, pixel_index, 2'b00};
	assign master_read = (state == ST_READ);
	// Bus released only while reading or stalled on pending reads
	assign master_arbiterlock = !((state == ST_READ) || (state == ST_STALL));

	// Every returned word goes straight to the FIFO
	assign beat_write = mem_rsp.readdatavalid;
	always_comb
	begin
		beat.data = mem_rsp.readdata[PIXEL_W-1:0];
		beat.sop = (rsp_index == '0);
		beat.eop = (rsp_index == FRAME_LAST);
	end

endmodule

// File: design/video_dma_pixel_fifo.sv
// Show-ahead pixel FIFO with fill marks driving the packet stream output
module video_dma_pixel_fifo (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              beat_write,
	input  video_dma_pkg::pixel_beat_t        beat,
	input  logic                              stream_ready,
	output logic [video_dma_pkg::PIXEL_W-1:0] stream_data,
	output logic                              stream_startofpacket,
	output logic                              stream_endofpacket,
	output logic                              stream_valid,
	output logic                              fifo_low,
	output logic                              fifo_high
);
	import video_dma_pkg::*;

	pixel_beat_t           mem [FIFO_DEPTH];
	pixel_beat_t           head;
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  full;
	logic                  do_write;
	logic                  do_read;

	assign full = (count == FIFO_CNT_W'(FIFO_DEPTH));
	// Writes while full are dropped
	assign do_write = beat_write && !full;
	assign do_read = stream_valid && stream_ready;

	// Storage array
	always_ff @(posedge clk)
	begin
		if (do_write)
			mem[wr_ptr] <= beat;
	end

	// Pointers wrap naturally at the power-of-two depth
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Occupancy
	always_ff @(posedge clk)
	begin
		if (reset)
			count <= '0;
		else
		begin
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head entry shows through without a read request
	assign head = mem[rd_ptr];
	assign stream_data = head.data;
	assign stream_startofpacket = head.sop;
	assign stream_endofpacket = head.eop;
	assign stream_valid = (count != '0);

	// Fill marks back to the fetch engine
	assign fifo_low = (count < FIFO_CNT_W'(FIFO_LOW_MARK));
	assign fifo_high = (count >= FIFO_CNT_W'(FIFO_HIGH_MARK));

endmodule

// File: design/video_dma.sv
// Video DMA top joining the register decoder, fetch engine and pixel FIFO
module video_dma (
	input  logic                              clk,
	input  logic                              reset,
	input  video_dma_pkg::slave_cmd_t         slave_cmd,
	output logic [31:0]                       slave_readdata,
	input  video_dma_pkg::mem_rsp_t           mem_rsp,
	output logic [31:0]                       master_address,
	output logic                              master_read,
	output logic                              master_arbiterlock,
	input  logic                              stream_ready,
	output logic [video_dma_pkg::PIXEL_W-1:0] stream_data,
	output logic                              stream_startofpacket,
	output logic                              stream_endofpacket,
	output logic                              stream_valid
);
	import video_dma_pkg::*;

	logic [31:0] front_base;
	logic        frame_done;
	logic        beat_write;
	pixel_beat_t beat;
	logic        fifo_low;
	logic        fifo_high;

	// Decode stage
	video_dma_regs u_regs (
		.clk            (clk),
		.reset          (reset),
		.slave_cmd      (slave_cmd),
		.frame_done     (frame_done),
		.slave_readdata (slave_readdata),
		.front_base     (front_base)
	);

	// Execute stage
	video_dma_fetch u_fetch (
		.clk                (clk),
		.reset              (reset),
		.front_base         (front_base),
		.mem_rsp            (mem_rsp),
		.fifo_low           (fifo_low),
		.fifo_high          (fifo_high),
		.master_address     (master_address),
		.master_read        (master_read),
		.master_arbiterlock (master_arbiterlock),
		.frame_done         (frame_done),
		.beat_write         (beat_write),
		.beat               (beat)
	);

	// Result stage and stream port
	video_dma_pixel_fifo u_fifo (
		.clk                  (clk),
		.reset                (reset),
		.beat_write           (beat_write),
		.beat                 (beat),
		.stream_ready         (stream_ready),
		.stream_data          (stream_data),
		.stream_startofpacket (stream_startofpacket),
		.stream_endofpacket   (stream_endofpacket),
		.stream_valid         (stream_valid),
		.fifo_low             (fifo_low),
		.fifo_high            (fifo_high)
	);

endmodule

// File: tb/video_dma_assert.sv
// Protocol assertions for the video DMA read master, pending limit and stream port
module video_dma_assert (
	input logic                              clk,
	input logic                              reset,
	input video_dma_pkg::mem_rsp_t           mem_rsp,
	input logic [31:0]                       master_address,
	input logic                              master_read,
	input logic [video_dma_pkg::PENDING_W-1:0] pending_count,
	input logic                              stream_ready,
	input logic [video_dma_pkg::PIXEL_W-1:0] stream_data,
	input logic                              stream_startofpacket,
	input logic                              stream_endofpacket,
	input logic                              stream_valid
);
	timeunit 1ns;
	timeprecision 100ps;
	import video_dma_pkg::*;

	// Failed assertions, summed into the testbench result
	int unsigned fail_count = 0;

	// Request held steady until the memory takes it
	assert property (@(posedge clk) disable iff (reset)
		master_read && mem_rsp.waitrequest |=> master_read && $stable(master_address))
	else
	begin
		$error("Read request changed while waitrequest was high");
		fail_count++;
	end

	// One read may land on the stall edge
	assert property (@(posedge clk) disable iff (reset)
		pending_count <= PENDING_W'(MAX_PENDING + 1))
	else
	begin
		$error("Outstanding read count above limit: %0d", pending_count);
		fail_count++;
	end

	// Stalled stream holds its beat
	assert property (@(posedge clk) disable iff (reset)
		stream_valid && !stream_ready |=> stream_valid && $stable(stream_data)
			&& $stable(stream_startofpacket) && $stable(stream_endofpacket))
	else
	begin
		$error("Stream beat changed while stalled");
		fail_count++;
	end

endmodule

bind video_dma video_dma_assert u_assert (
	.clk                  (clk),
	.reset                (reset),
	.mem_rsp              (mem_rsp),
	.master_address       (master_address),
	.master_read          (master_read),
	.pending_count        (u_fetch.pending_count),
	.stream_ready         (stream_ready),
	.stream_data          (stream_data),
	.stream_startofpacket (stream_startofpacket),
	.stream_endofpacket   (stream_endofpacket),
	.stream_valid         (stream_valid)
);

// File: tb/video_dma_tb.sv
// Testbench for the video DMA running register and frame cases from a data file
module video_dma_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import video_dma_pkg::*;

	localparam int BEAT_TIMEOUT = 600;
	localparam logic [31:0] PIXEL_MASK = (32'd1 << PIXEL_W) - 32'd1;

	logic                 clk = 1'b0;
	logic                 reset = 1'b1;
	slave_cmd_t           slave_cmd = '0;
	logic [31:0]          slave_readdata;
	mem_rsp_t             mem_rsp = '0;
	logic [31:0]          master_address;
	logic                 master_read;
	logic                 master_arbiterlock;
	logic                 stream_ready = 1'b0;
	logic [PIXEL_W-1:0]   stream_data;
	logic                 stream_startofpacket;
	logic                 stream_endofpacket;
	logic                 stream_valid;

	int seed = 81547;
	int cycle = 0;
	int case_no = 0;
	int checks = 0;
	int errors = 0;
	logic timed_out = 1'b0;
	// Memory model, in-order responses with due cycles
	logic [31:0] rsp_data_q[$];
	int          rsp_due_q[$];
	int          last_due = 0;
	// Stream sink state
	pixel_beat_t rx_q[$];
	int          frames_left = 0;
	int          ready_mode = 0;
	int          stall_left = 0;

	video_dma UUT (
		.clk                  (clk),
		.reset                (reset),
		.slave_cmd            (slave_cmd),
		.slave_readdata       (slave_readdata),
		.mem_rsp              (mem_rsp),
		.master_address       (master_address),
		.master_read          (master_read),
		.master_arbiterlock   (master_arbiterlock),
		.stream_ready         (stream_ready),
		.stream_data          (stream_data),
		.stream_startofpacket (stream_startofpacket),
		.stream_endofpacket   (stream_endofpacket),
		.stream_valid         (stream_valid)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// Memory and stream sink, both decided before the coming rising edge
	always @(negedge clk)
	begin
		int lat;
		cycle++;
		// Lock low while reading, high once nothing is in flight
		if (!reset)
		begin
			if (master_read)
				check_flag(master_arbiterlock, 1'b0, "master_arbiterlock while reading");
			else if (rsp_due_q.size() == 0)
				check_flag(master_arbiterlock, 1'b1,
					"master_arbiterlock with no reads in flight");
		end
		if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle)
		begin
			void'(rsp_due_q.pop_front());
			mem_rsp.readdata = rsp_data_q.pop_front();
			mem_rsp.readdatavalid = 1'b1;
		end
		else
		begin
			mem_rsp.readdata = 32'h0;
			mem_rsp.readdatavalid = 1'b0;
		end
		// Wait state on about one cycle in four
		mem_rsp.waitrequest = ($unsigned($random(seed)) % 4) == 0;
		if (!reset && master_read && !mem_rsp.waitrequest)
		begin
			// 1 to 4 cycles, never overtaking an older read
			lat = 1 + $unsigned($random(seed)) % 4;
			last_due = (cycle + lat > last_due) ? cycle + lat : last_due + 1;
			rsp_due_q.push_back(last_due);
			rsp_data_q.push_back((master_address >> 2) & PIXEL_MASK);
		end
		// Sink only runs while frames are requested
		if (frames_left == 0)
			stream_ready = 1'b0;
		else if (ready_mode == 0)
			stream_ready = ($unsigned($random(seed)) % 4) != 0;
		else if (stall_left > 0)
		begin
			stream_ready = 1'b0;
			stall_left--;
		end
		else
		begin
			stream_ready = 1'b1;
			// Long stall now and then
			if ($unsigned($random(seed)) % 8 == 0)
				stall_left = 30 + $unsigned($random(seed)) % 40;
		end
		if (stream_ready && stream_valid)
		begin
			rx_q.push_back({stream_data, stream_startofpacket, stream_endofpacket});
			if (stream_endofpacket)
				frames_left--;
		end
	end

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_beat(input pixel_beat_t got, input pixel_beat_t exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s data %h sop %b eop %b, expected %h sop %b eop %b",
				$time, what, got.data, got.sop, got.eop, exp.data, exp.sop, exp.eop);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic finish_run();
		errors += UUT.u_assert.fail_count;
		$display("Cases: %0d, checks: %0d, errors: %0d", case_no, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [31:0] data,
		input logic [3:0] be);
		@(negedge clk);
		slave_cmd.address = addr;
		slave_cmd.byteenable = be;
		slave_cmd.writedata = data;
		slave_cmd.write = 1'b1;
		@(negedge clk);
		slave_cmd.write = 1'b0;
	endtask

	// Readback is registered, one cycle after the strobe
	task automatic read_reg(input logic [1:0] addr, output logic [31:0] data);
		@(negedge clk);
		slave_cmd.address = addr;
		slave_cmd.read = 1'b1;
		@(negedge clk);
		slave_cmd.read = 1'b0;
		data = slave_readdata;
	endtask

	// Pulls n whole frames through the sink and checks every beat
	task automatic check_frames(input int n, input logic [31:0] base, input int mode);
		pixel_beat_t exp;
		int pos;
		int wait_cycles;
		@(posedge clk);
		ready_mode = mode;
		frames_left = n;
		for (int i = 0; i < n * FRAME_WORDS; i++)
		begin
			pos = i % FRAME_WORDS;
			wait_cycles = 0;
			while (rx_q.size() == 0 && wait_cycles < BEAT_TIMEOUT)
			begin
				@(posedge clk);
				wait_cycles++;
			end
			if (rx_q.size() == 0)
			begin
				$display("Timeout: no stream beat for frame position %0d within %0d cycles",
					pos, BEAT_TIMEOUT);
				errors++;
				timed_out = 1'b1;
				return;
			end
			// Word index of base plus four bytes per position
			exp.data = PIXEL_W'((base + 32'(4 * pos)) >> 2);
			exp.sop = (pos == 0);
			exp.eop = (pos == FRAME_WORDS - 1);
			check_beat(rx_q.pop_front(), exp, $sformatf("frame beat %0d", pos));
		end
	endtask

	initial
	begin
		int fd;
		int op;
		int errors_before;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] word;
		string line;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		fd = $fopen("tb/video_dma_cases.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open case file tb/video_dma_cases.txt");
			errors++;
		end
		// Stops early when a frame case runs out of time
		while (fd != 0 && !timed_out && $fgets(line, fd) > 0)
		begin
			// Comment and blank lines carry fewer than three fields
			if ($sscanf(line, "%d %h %h %h", op, a, b, c) < 3)
				continue;
			case_no++;
			errors_before = errors;
			case (op)
				1:
				begin
					write_reg(a[1:0], b, c[3:0]);
					$display("Case %0d: write reg %0d data %h byteenable %h done",
						case_no, a[1:0], b, c[3:0]);
				end
				2:
				begin
					read_reg(a[1:0], word);
					check_word(word, b, $sformatf("register %0d", a[1:0]));
					$display("Case %0d: read reg %0d %s", case_no, a[1:0],
						(errors == errors_before) ? "ok" : "mismatch");
				end
				3:
				begin
					check_frames(int'(a), b, int'(c));
					$display("Case %0d: %0d frames from base %h, ready mode %0d %s",
						case_no, a, b, c, (errors == errors_before) ? "ok" : "mismatch");
				end
				default:
				begin
					errors++;
					$display("Case %0d: unknown operation code %0d", case_no, op);
				end
			endcase
		end
		if (fd != 0)
			$fclose(fd);
		finish_run();
	end

endmodule

// File: tb/video_dma_cases.txt
# op 1 = write: reg data byteenable | op 2 = read: reg expected
# op 3 = frames: count base ready_mode (0 random ready, 1 long stalls)
2 0 00001000
2 1 00002000
2 2 00040008
2 3 00060032
1 1 aabbccdd 5
2 1 00bb20dd
1 1 00003000 f
2 1 00003000
3 2 00001000 0
3 2 00001000 1
1 0 12345678 f
2 0 00001000
2 3 00060033
3 1 00001000 0
3 3 00003000 1
2 0 00003000
2 1 00001000
2 3 00060032

// File: sim.f
design/video_dma_pkg.sv
design/video_dma_regs.sv
design/video_dma_fetch.sv
design/video_dma_pixel_fifo.sv
design/video_dma.sv
tb/video_dma_assert.sv
tb/video_dma_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP := video_dma_tb
FILELIST := sim.f
COMMON_FLAGS := --timing --assert --timescale 1ns/100ps
LINT_FLAGS := --lint-only $(COMMON_FLAGS)
SIM_FLAGS := --binary $(COMMON_FLAGS) -j 0
BUILD_DIR := obj_dir
LOG := sim.log
PASS_MSG := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
